// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := board_periph_tb
FILELIST  := list.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o V$(TOP)
	./$(OBJDIR)/V$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1; \
	status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "test failed" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: hdl/board_periph_top.sv
/* Board glue top: reset combining, boot mode select, RTC tick, fan PWM and pads.
   The SoC sits outside, its pin signals are ports here. */

module board_periph_top #(
  parameter int unsigned RstStages   = 4,
  parameter int unsigned RtcHalfDiv  = 25,
  parameter int unsigned FanPrescale = 2
) (
  input  logic                  soc_clk,
  input  logic                  rst_n,
  // Board reset and debug controls
  input  logic                  cpu_reset_n_i,
  input  logic                  dbg_reset_i,
  input  logic                  testmode_i,
  input  board_pkg::boot_mode_t boot_sw_i,
  input  logic                  dbg_boot_sel_i,
  input  board_pkg::boot_mode_t dbg_boot_mode_i,
  input  board_pkg::fan_level_t fan_sw_i,
  // SoC pin side
  input  board_pkg::soc_spi_t   spi_soc_i,
  input  board_pkg::i2c_soc_t   i2c_soc_i,
  // Board pin side
  input  logic                  sd_dat0_i,
  input  logic                  sda_pad_i,
  input  logic                  scl_pad_i,
  input  logic                  sd_cd_i,
  output logic                  rst_n_o,
  output board_pkg::boot_mode_t boot_mode_o,
  output logic                  rtc_o,
  output logic                  fan_pwm_o,
  output board_pkg::sd_pads_t   sd_pads_o,
  output logic [3:0]            spi_sd_in_o,
  output board_pkg::i2c_pad_t   i2c_pads_o,
  // Bit 1 SCL, bit 0 SDA
  output logic [1:0]            i2c_soc_in_o,
  output logic                  sd_cd_sync_o
);

  //////////////////////////////////////////////////
  // Reset
  //////////////////////////////////////////////////

  logic sys_rst;
  logic rst_req_n;
  logic soc_rst_n;

  // Button low or debug reset high requests a system reset
  assign sys_rst   = ~cpu_reset_n_i | dbg_reset_i;
  assign rst_req_n = rst_n & ~sys_rst;

  board_rst_gen #(
    .RstStages   (RstStages)
  ) u_board_rst_gen (
    .soc_clk     (soc_clk),
    .rst_n       (rst_req_n),
    .test_mode_i (testmode_i),
    .rst_n_o     (soc_rst_n),
    .init_n_o    ()
  );

  assign rst_n_o = soc_rst_n;

  //////////////////////////////////////////////////
  // Boot mode
  //////////////////////////////////////////////////

  // Debug override wins over the switches
  assign boot_mode_o = dbg_boot_sel_i ? dbg_boot_mode_i : boot_sw_i;

  //////////////////////////////////////////////////
  // RTC and fan
  //////////////////////////////////////////////////

  rtc_div #(
    .RtcHalfDiv (RtcHalfDiv)
  ) u_rtc_div (
    .soc_clk    (soc_clk),
    .rst_n      (soc_rst_n),
    .rtc_o      (rtc_o)
  );

  fan_pwm_ctrl #(
    .FanPrescale   (FanPrescale)
  ) u_fan_pwm_ctrl (
    .soc_clk       (soc_clk),
    .rst_n         (soc_rst_n),
    .pwm_setting_i (fan_sw_i),
    .fan_pwm_o     (fan_pwm_o)
  );

  //////////////////////////////////////////////////
  // Pads
  //////////////////////////////////////////////////

  pad_adapt u_pad_adapt (
    .soc_clk      (soc_clk),
    .rst_n        (soc_rst_n),
    .spi_i        (spi_soc_i),
    .sd_dat0_i    (sd_dat0_i),
    .sd_pads_o    (sd_pads_o),
    .spi_sd_in_o  (spi_sd_in_o),
    .i2c_i        (i2c_soc_i),
    .sda_pad_i    (sda_pad_i),
    .scl_pad_i    (scl_pad_i),
    .i2c_pads_o   (i2c_pads_o),
    .i2c_sda_in_o (i2c_soc_in_o[0]),
    .i2c_scl_in_o (i2c_soc_in_o[1]),
    .sd_cd_i      (sd_cd_i),
    .sd_cd_sync_o (sd_cd_sync_o)
  );

endmodule

// File: hdl/board_pkg.sv
/* Shared types for the board glue around the SoC.
   Blocks refer to these by scoped name, board_pkg::name. */

package board_pkg;

  //////////////////////////////////////////////////
  // Scalar types
  //////////////////////////////////////////////////

  // Fan switch level, equal to the PWM slots driven high
  typedef logic [3:0] fan_level_t;

  // Boot source code handed to the SoC
  typedef logic [1:0] boot_mode_t;

  // Slots in one PWM period
  localparam int unsigned FanSlots = 16;

  //////////////////////////////////////////////////
  // Pin bundles
  //////////////////////////////////////////////////

  // SPI host outputs of the SoC, each with its own drive enable
  typedef struct packed {
    logic       sck;
    logic       sck_en;
    logic [1:0] csb;
    logic [1:0] csb_en;
    logic [3:0] sd;
    logic [3:0] sd_en;
  } soc_spi_t;

  // SD card pins in SPI mode
  typedef struct packed {
    logic       sclk;
    logic       cmd;
    logic       dat3;
    logic [1:0] dat21;
    logic       card_reset;
  } sd_pads_t;

  // I2C outputs of the SoC
  typedef struct packed {
    logic sda_o;
    logic sda_en;
    logic scl_o;
    logic scl_en;
  } i2c_soc_t;

  // Open-drain pad controls, 1 pulls the line low
  typedef struct packed {
    logic sda_oe;
    logic scl_oe;
  } i2c_pad_t;

endpackage

// File: hdl/board_rst_gen.sv
/* Reset generator: asserts asynchronously, releases through a flop chain.
   In test mode the chain is bypassed so scan controls the reset. */

module board_rst_gen #(
  parameter int unsigned RstStages = 4
) (
  input  logic soc_clk,
  input  logic rst_n,
  input  logic test_mode_i,
  output logic rst_n_o,
  output logic init_n_o
);

  //////////////////////////////////////////////////
  // Release chain
  //////////////////////////////////////////////////

  logic [RstStages-1:0] sync_q;

  // Ones shift in after the request drops
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q <= '0;
    end else begin
      if (RstStages > 1) begin
        sync_q <= {sync_q[RstStages-2:0], 1'b1};
      end else begin
        sync_q <= '1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////

  // Scan bypass
  always_comb begin
    if (test_mode_i) begin
      rst_n_o = rst_n;
    end else begin
      rst_n_o = sync_q[RstStages-1];
    end
  end

  // Init marker always sees the synchronized release
  assign init_n_o = sync_q[RstStages-1];

endmodule

// File: hdl/fan_pwm_ctrl.sv
/* Fan PWM from the 4-bit switch level: FanSlots slots of FanPrescale cycles.
   The level is sampled once per period so a switch change cannot glitch it. */

module fan_pwm_ctrl #(
  parameter int unsigned FanPrescale = 2
) (
  input  logic                   soc_clk,
  input  logic                   rst_n,
  input  board_pkg::fan_level_t  pwm_setting_i,
  output logic                   fan_pwm_o
);

  localparam int unsigned PreW  = (FanPrescale > 1) ? $clog2(FanPrescale) : 1;
  localparam int unsigned SlotW = $clog2(board_pkg::FanSlots);
  localparam logic [PreW-1:0]  PreLast  = PreW'(FanPrescale - 1);
  localparam logic [SlotW-1:0] SlotLast = SlotW'(board_pkg::FanSlots - 1);

  logic [PreW-1:0]       pre_d;
  logic [PreW-1:0]       pre_q;
  logic [SlotW-1:0]      slot_d;
  logic [SlotW-1:0]      slot_q;
  board_pkg::fan_level_t level_d;
  board_pkg::fan_level_t level_q;
  logic                  pwm_q;

  //////////////////////////////////////////////////
  // Prescaler and slot counter
  //////////////////////////////////////////////////

  always_comb begin
    pre_d   = pre_q + 1'b1;
    slot_d  = slot_q;
    level_d = level_q;
    if (pre_q == PreLast) begin
      pre_d = '0;
      if (slot_q == SlotLast) begin
        // New period, take the switch level now
        slot_d  = '0;
        level_d = pwm_setting_i;
      end else begin
        slot_d = slot_q + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // State and registered output
  //////////////////////////////////////////////////

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      pre_q   <= '0;
      slot_q  <= '0;
      level_q <= '0;
      pwm_q   <= 1'b0;
    end else begin
      pre_q   <= pre_d;
      slot_q  <= slot_d;
      level_q <= level_d;
      // High while inside the first level_q slots
      pwm_q   <= (slot_d < level_d);
    end
  end

  assign fan_pwm_o = pwm_q;

endmodule

// File: hdl/pad_adapt.sv
/* Maps SoC SPI host pins onto an SD card in SPI mode and I2C onto open-drain
   pad controls. Card detect is synchronized into soc_clk. */

module pad_adapt (
  input  logic                soc_clk,
  input  logic                rst_n,
  input  board_pkg::soc_spi_t spi_i,
  input  logic                sd_dat0_i,
  output board_pkg::sd_pads_t sd_pads_o,
  output logic [3:0]          spi_sd_in_o,
  input  board_pkg::i2c_soc_t i2c_i,
  input  logic                sda_pad_i,
  input  logic                scl_pad_i,
  output board_pkg::i2c_pad_t i2c_pads_o,
  output logic                i2c_sda_in_o,
  output logic                i2c_scl_in_o,
  input  logic                sd_cd_i,
  output logic                sd_cd_sync_o
);

  //////////////////////////////////////////////////
  // SD card in SPI mode
  //////////////////////////////////////////////////

  // Idle lines sit high when the host releases them
  always_comb begin
    sd_pads_o.sclk  = spi_i.sck_en ? spi_i.sck : 1'b1;
    // Chip select 0 on DAT3
    sd_pads_o.dat3  = spi_i.csb_en[0] ? spi_i.csb[0] : 1'b1;
    // MOSI on CMD
    sd_pads_o.cmd   = spi_i.sd_en[0] ? spi_i.sd[0] : 1'b1;
    // Unused in SPI mode
    sd_pads_o.dat21 = 2'b11;
    // Card stays powered
    sd_pads_o.card_reset = 1'b0;
  end

  // MISO from DAT0 returns on bit 1
  assign spi_sd_in_o = {2'b00, sd_dat0_i, 1'b0};

  //////////////////////////////////////////////////
  // I2C open drain
  //////////////////////////////////////////////////

  // Pull low only for a driven zero
  assign i2c_pads_o.sda_oe = i2c_i.sda_en & ~i2c_i.sda_o;
  assign i2c_pads_o.scl_oe = i2c_i.scl_en & ~i2c_i.scl_o;

  assign i2c_sda_in_o = sda_pad_i;
  assign i2c_scl_in_o = scl_pad_i;

  //////////////////////////////////////////////////
  // Card detect synchronizer
  //////////////////////////////////////////////////

  logic [1:0] cd_sync_q;

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      cd_sync_q <= 2'b00;
    end else begin
      cd_sync_q <= {cd_sync_q[0], sd_cd_i};
    end
  end

  assign sd_cd_sync_o = cd_sync_q[1];

endmodule

// File: hdl/rtc_div.sv
/* Divides soc_clk into the square real-time-clock reference of the SoC.
   Period is twice RtcHalfDiv cycles, low out of reset. */

module rtc_div #(
  parameter int unsigned RtcHalfDiv = 25
) (
  input  logic soc_clk,
  input  logic rst_n,
  output logic rtc_o
);

  localparam int unsigned CntW = (RtcHalfDiv > 1) ? $clog2(RtcHalfDiv) : 1;
  localparam logic [CntW-1:0] CntLast = CntW'(RtcHalfDiv - 1);

  logic [CntW-1:0] cnt_d;
  logic [CntW-1:0] cnt_q;
  logic            rtc_d;
  logic            rtc_q;

  // Wrap the counter and flip the clock bit on each wrap
  always_comb begin
    cnt_d = cnt_q + 1'b1;
    rtc_d = rtc_q;
    if (cnt_q == CntLast) begin
      cnt_d = '0;
      rtc_d = ~rtc_q;
    end
  end

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
      rtc_q <= 1'b0;
    end else begin
      cnt_q <= cnt_d;
      rtc_q <= rtc_d;
    end
  end

  assign rtc_o = rtc_q;

endmodule

// File: list.f
hdl/board_pkg.sv
hdl/board_rst_gen.sv
hdl/rtc_div.sv
hdl/fan_pwm_ctrl.sv
hdl/pad_adapt.sv
hdl/board_periph_top.sv
sim/board_periph_checker.sv
sim/board_periph_tb.sv

// File: sim/board_periph_checker.sv
/* Concurrent assertions on the board glue top, attached with bind.
   Covers the SD and I2C pin mapping, boot mode select and the RTC period. */

module board_periph_checker #(
  parameter int unsigned RtcHalfDiv = 5
) (
  input logic                  soc_clk,
  input logic                  rst_n,
  input board_pkg::soc_spi_t   spi_i,
  input logic                  sd_dat0_i,
  input board_pkg::sd_pads_t   sd_pads_i,
  input logic [3:0]            spi_sd_in_i,
  input board_pkg::i2c_soc_t   i2c_i,
  input logic                  sda_pad_i,
  input logic                  scl_pad_i,
  input board_pkg::i2c_pad_t   i2c_pads_i,
  input logic [1:0]            i2c_soc_in_i,
  input board_pkg::boot_mode_t boot_sw_i,
  input logic                  dbg_boot_sel_i,
  input board_pkg::boot_mode_t dbg_boot_mode_i,
  input board_pkg::boot_mode_t boot_mode_i,
  input logic                  rtc_i
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_cnt = 0;

  // Released SD lines idle high
  function automatic board_pkg::sd_pads_t sd_expect(input board_pkg::soc_spi_t s);
    board_pkg::sd_pads_t p;
    p.sclk       = s.sck_en ? s.sck : 1'b1;
    p.cmd        = s.sd_en[0] ? s.sd[0] : 1'b1;
    p.dat3       = s.csb_en[0] ? s.csb[0] : 1'b1;
    p.dat21      = 2'b11;
    p.card_reset = 1'b0;
    return p;
  endfunction

  //////////////////////////////////////////////////
  // RTC run length
  //////////////////////////////////////////////////

  logic        rtc_prev;
  int unsigned run_len;

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      rtc_prev <= 1'b0;
      run_len  <= 0;
    end else begin
      rtc_prev <= rtc_i;
      run_len  <= (rtc_i != rtc_prev) ? 1 : run_len + 1;
    end
  end

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////

  sd_map_a: assert property (@(posedge soc_clk)
    sd_pads_i == sd_expect(spi_i) && spi_sd_in_i == {2'b00, sd_dat0_i, 1'b0})
    else begin
      $error("[ERROR] sd_map: expected %h/%h actual %h/%h", sd_expect(spi_i),
             {2'b00, sd_dat0_i, 1'b0}, sd_pads_i, spi_sd_in_i);
      fail_cnt++;
    end

  // Pull low only for an enabled zero
  i2c_pull_a: assert property (@(posedge soc_clk)
    i2c_pads_i.sda_oe == (i2c_i.sda_en && !i2c_i.sda_o) &&
    i2c_pads_i.scl_oe == (i2c_i.scl_en && !i2c_i.scl_o) &&
    i2c_soc_in_i == {scl_pad_i, sda_pad_i})
    else begin
      $error("[ERROR] i2c_pads: expected %b%b/%b%b actual %b/%b",
             i2c_i.sda_en && !i2c_i.sda_o, i2c_i.scl_en && !i2c_i.scl_o,
             scl_pad_i, sda_pad_i, i2c_pads_i, i2c_soc_in_i);
      fail_cnt++;
    end

  boot_sel_a: assert property (@(posedge soc_clk)
    boot_mode_i == (dbg_boot_sel_i ? dbg_boot_mode_i : boot_sw_i))
    else begin
      $error("[ERROR] boot_mode: expected %0d actual %0d",
             dbg_boot_sel_i ? dbg_boot_mode_i : boot_sw_i, boot_mode_i);
      fail_cnt++;
    end

  rtc_period_a: assert property (@(posedge soc_clk) disable iff (!rst_n)
    (rtc_i != rtc_prev) |-> run_len == RtcHalfDiv)
    else begin
      $error("[ERROR] rtc_half_period: expected %0d actual %0d", RtcHalfDiv, run_len);
      fail_cnt++;
    end

endmodule

bind board_periph_top board_periph_checker #(
  .RtcHalfDiv (RtcHalfDiv)
) u_checker (
  .soc_clk         (soc_clk),
  .rst_n           (rst_n_o),
  .spi_i           (spi_soc_i),
  .sd_dat0_i       (sd_dat0_i),
  .sd_pads_i       (sd_pads_o),
  .spi_sd_in_i     (spi_sd_in_o),
  .i2c_i           (i2c_soc_i),
  .sda_pad_i       (sda_pad_i),
  .scl_pad_i       (scl_pad_i),
  .i2c_pads_i      (i2c_pads_o),
  .i2c_soc_in_i    (i2c_soc_in_o),
  .boot_sw_i       (boot_sw_i),
  .dbg_boot_sel_i  (dbg_boot_sel_i),
  .dbg_boot_mode_i (dbg_boot_mode_i),
  .boot_mode_i     (boot_mode_o),
  .rtc_i           (rtc_o)
);

// File: sim/board_periph_tb.sv
/* Testbench for the board glue top: drives the SoC and board pins and runs each test.
   Counts PWM and RTC timing here, the bound checker covers the pin mappings. */

module board_periph_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned RstStages   = 4;
  localparam int unsigned RtcHalfDiv  = 5;
  localparam int unsigned FanPrescale = 2;
  localparam int unsigned PwmPeriod   = board_pkg::FanSlots * FanPrescale;
  // Settle time after a fan change, the new level lands within one period
  localparam int unsigned PwmSettle   = PwmPeriod + 8;
  // About 1.1k cycles of tests, the PWM sweep dominates
  localparam int unsigned TimeoutCycles = 2000;

  logic                  soc_clk = 1'b0;
  logic                  cpu_reset_n;
  logic                  dbg_reset;
  logic                  testmode;
  board_pkg::boot_mode_t boot_sw;
  logic                  dbg_boot_sel;
  board_pkg::boot_mode_t dbg_boot_mode;
  board_pkg::fan_level_t fan_sw;
  board_pkg::soc_spi_t   spi_soc;
  board_pkg::i2c_soc_t   i2c_soc;
  logic                  sd_dat0;
  logic                  sda_pad;
  logic                  scl_pad;
  logic                  sd_cd;
  logic                  rst_n_o;
  board_pkg::boot_mode_t boot_mode;
  logic                  rtc;
  logic                  fan_pwm;
  board_pkg::sd_pads_t   sd_pads;
  logic [3:0]            spi_sd_in;
  board_pkg::i2c_pad_t   i2c_pads;
  logic [1:0]            i2c_soc_in;
  logic                  sd_cd_sync;

  int seed = 3762;
  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int err_mark = 0;
  int cycles = 0;

  board_periph_top #(
    .RstStages   (RstStages),
    .RtcHalfDiv  (RtcHalfDiv),
    .FanPrescale (FanPrescale)
  ) u_board_periph_top (
    .soc_clk         (soc_clk),
    .rst_n           (cpu_reset_n),
    .cpu_reset_n_i   (cpu_reset_n),
    .dbg_reset_i     (dbg_reset),
    .testmode_i      (testmode),
    .boot_sw_i       (boot_sw),
    .dbg_boot_sel_i  (dbg_boot_sel),
    .dbg_boot_mode_i (dbg_boot_mode),
    .fan_sw_i        (fan_sw),
    .spi_soc_i       (spi_soc),
    .i2c_soc_i       (i2c_soc),
    .sd_dat0_i       (sd_dat0),
    .sda_pad_i       (sda_pad),
    .scl_pad_i       (scl_pad),
    .sd_cd_i         (sd_cd),
    .rst_n_o         (rst_n_o),
    .boot_mode_o     (boot_mode),
    .rtc_o           (rtc),
    .fan_pwm_o       (fan_pwm),
    .sd_pads_o       (sd_pads),
    .spi_sd_in_o     (spi_sd_in),
    .i2c_pads_o      (i2c_pads),
    .i2c_soc_in_o    (i2c_soc_in),
    .sd_cd_sync_o    (sd_cd_sync)
  );

  always #50 soc_clk = ~soc_clk;

  // Watchdog
  always @(posedge soc_clk) begin
    cycles <= cycles + 1;
    if (cycles >= TimeoutCycles) begin
      $display("timeout: tests did not complete within %0d cycles", TimeoutCycles);
      $display("test failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic int fail_total();
    return errors + u_board_periph_top.u_checker.fail_cnt;
  endfunction

  task automatic check_value(input string name, input int exp, input int act);
    if (exp != act) begin
      errors++;
      $display("[ERROR] %s: expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic end_test(input string name);
    int now;
    now = fail_total();
    tests_run++;
    if (now == err_mark) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d failures", name, now - err_mark);
    end
    err_mark = now;
  endtask

  // Pulse the debug reset and wait for the release
  task automatic pulse_dbg_reset();
    int n;
    @(posedge soc_clk);
    dbg_reset <= 1'b1;
    @(posedge soc_clk);
    dbg_reset <= 1'b0;
    n = 0;
    while (rst_n_o !== 1'b1 && n < 40) begin
      @(negedge soc_clk);
      n++;
    end
    if (rst_n_o !== 1'b1) begin
      errors++;
      $display("reset output never released after the debug reset");
    end
  endtask

  task automatic cycles_to_rtc_rise(output int n);
    logic prev;
    logic hit;
    n = 0;
    hit = 1'b0;
    prev = rtc;
    while (!hit && n < 4 * RtcHalfDiv) begin
      @(negedge soc_clk);
      n++;
      hit = rtc && !prev;
      prev = rtc;
    end
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic test_reset();
    int  n;
    logic done;
    // Start from a released reset
    pulse_dbg_reset();
    @(posedge soc_clk);
    dbg_reset <= 1'b1;
    @(negedge soc_clk);
    check_value("reset_assert", 0, int'(rst_n_o));
    @(posedge soc_clk);
    dbg_reset <= 1'b0;
    n = 0;
    done = 1'b0;
    while (!done && n < 20) begin
      @(posedge soc_clk);
      n++;
      @(negedge soc_clk);
      done = rst_n_o;
    end
    check_value("reset_release", RstStages, n);
    // Scan bypass
    @(posedge soc_clk);
    testmode <= 1'b1;
    @(posedge soc_clk);
    dbg_reset <= 1'b1;
    @(negedge soc_clk);
    check_value("testmode_assert", 0, int'(rst_n_o));
    @(posedge soc_clk);
    dbg_reset <= 1'b0;
    @(negedge soc_clk);
    check_value("testmode_release", 1, int'(rst_n_o));
    repeat (RstStages + 2) @(posedge soc_clk);
    testmode <= 1'b0;
    @(negedge soc_clk);
    check_value("testmode_exit", 1, int'(rst_n_o));
    end_test("reset");
  endtask

  task automatic test_rtc();
    int n;
    pulse_dbg_reset();
    check_value("rtc_reset_level", 0, int'(rtc));
    cycles_to_rtc_rise(n);
    repeat (3) begin
      cycles_to_rtc_rise(n);
      check_value("rtc_period", 2 * RtcHalfDiv, n);
    end
    end_test("rtc");
  endtask

  task automatic test_pwm();
    int                    s;
    int                    high;
    board_pkg::fan_level_t lvl;
    for (int k = 0; k < 11; k++) begin
      if (k == 0) s = 0;
      else if (k == 1) s = 5;
      else if (k == 2) s = 15;
      else s = $random(seed) & 15;
      lvl = board_pkg::fan_level_t'(s);
      @(posedge soc_clk);
      fan_sw <= lvl;
      repeat (PwmSettle) @(posedge soc_clk);
      // Any window of one period holds the full high time
      high = 0;
      repeat (PwmPeriod) begin
        @(negedge soc_clk);
        if (fan_pwm) high++;
      end
      check_value("pwm_high", s * FanPrescale, high);
    end
    end_test("pwm");
  endtask

  task automatic test_spi();
    logic [31:0] r;
    repeat (16) begin
      r = $random(seed);
      @(posedge soc_clk);
      spi_soc <= r[13:0];
      sd_dat0 <= r[14];
    end
    @(posedge soc_clk);
    @(negedge soc_clk);
    end_test("sd_spi");
  endtask

  task automatic test_i2c_cd();
    logic [31:0] r;
    logic        cur;
    repeat (16) begin
      r = $random(seed);
      @(posedge soc_clk);
      i2c_soc <= r[3:0];
      sda_pad <= r[4];
      scl_pad <= r[5];
    end
    @(posedge soc_clk);
    cur = sd_cd;
    repeat (4) begin
      @(posedge soc_clk);
      sd_cd <= ~cur;
      @(negedge soc_clk);
      @(negedge soc_clk);
      check_value("cd_sync_hold", int'(cur), int'(sd_cd_sync));
      @(negedge soc_clk);
      check_value("cd_sync_follow", int'(!cur), int'(sd_cd_sync));
      cur = ~cur;
    end
    end_test("i2c_cd");
  endtask

  task automatic test_boot();
    logic [31:0] r;
    repeat (16) begin
      r = $random(seed);
      @(posedge soc_clk);
      boot_sw       <= r[1:0];
      dbg_boot_sel  <= r[2];
      dbg_boot_mode <= r[4:3];
    end
    @(posedge soc_clk);
    @(negedge soc_clk);
    end_test("boot_mode");
  endtask

  initial begin
    cpu_reset_n   = 1'b0;
    dbg_reset     = 1'b0;
    testmode      = 1'b0;
    boot_sw       = '0;
    dbg_boot_sel  = 1'b0;
    dbg_boot_mode = '0;
    fan_sw        = '0;
    spi_soc       = '0;
    i2c_soc       = '0;
    sd_dat0       = 1'b0;
    sda_pad       = 1'b1;
    scl_pad       = 1'b1;
    sd_cd         = 1'b0;
    repeat (8) @(posedge soc_clk);
    cpu_reset_n <= 1'b1;
    test_reset();
    test_rtc();
    test_pwm();
    test_spi();
    test_i2c_cd();
    test_boot();
    $display("tests run %0d, tests failed %0d, failed checks %0d",
             tests_run, tests_failed, fail_total());
    if (tests_failed == 0 && fail_total() == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
